/* verilog.f */
+incdir+verilog
+incdir+sim
verilog/rv32_pipe_pkg.sv
verilog/fet_dec_stage.sv
verilog/dec_exe_reg.sv
verilog/exe_mem_reg.sv
verilog/mem_wb_reg.sv
verilog/rv32_stage_regs.sv
sim/rv32_stage_regs_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the testbench with verilator, run it and scan the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=rv32_stage_regs_sim
log_file=sim.log

verilator --binary --timing --timescale 1ns/100ps -j 0 \
    -f verilog.f --top-module rv32_stage_regs_tb \
    --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$log_file"; then
    exit 1
fi
exit 0

/* sim/rv32_stage_stim.txt */
# pc instr rs1 rs2 read_word | exp_addr exp_be exp_wdata exp_wb_data exp_trap
# all fields hex, trap items expect no memory strobe
00001000 0100A283 10000000 00000000 CAFEBABE 10000010 F 00000000 CAFEBABE 0
00001004 00409283 10000000 00000000 12348765 10000004 3 00000000 FFFF8765 0
00001008 00609283 10000000 00000000 9ABC0011 10000004 C 00000000 FFFF9ABC 0
0000100C 00A0D283 10000000 00000000 80017FFF 10000008 C 00000000 00008001 0
00001010 0000D283 10000000 00000000 5555F00D 10000000 3 00000000 0000F00D 0
00001014 02008283 10000000 00000000 11223380 10000020 1 00000000 FFFFFF80 0
00001018 02108283 10000000 00000000 1122F344 10000020 2 00000000 FFFFFFF3 0
0000101C 02208283 10000000 00000000 11773344 10000020 4 00000000 00000077 0
00001020 02308283 10000000 00000000 A5223344 10000020 8 00000000 FFFFFFA5 0
00001024 0250C283 10000000 00000000 00009900 10000024 2 00000000 00000099 0
00001028 0270C283 10000000 00000000 EE000000 10000024 8 00000000 000000EE 0
0000102C FFC0A283 20000100 00000000 0BADF00D 200000FC F 00000000 0BADF00D 0
00001030 0020A423 10000000 A1B2C3D4 00000000 10000008 F A1B2C3D4 00000000 0
00001034 00209623 10000000 A1B2C3D4 00000000 1000000C 3 A1B2C3D4 00000000 0
00001038 00209723 10000000 A1B2C3D4 00000000 1000000C C C3D40000 00000000 0
0000103C 00208823 10000000 A1B2C3D4 00000000 10000010 1 A1B2C3D4 00000000 0
00001040 002088A3 10000000 A1B2C3D4 00000000 10000010 2 B2C3D400 00000000 0
00001044 002089A3 10000000 A1B2C3D4 00000000 10000010 8 D4000000 00000000 0
00001048 04208123 10000000 A1B2C3D4 00000000 10000040 4 C3D40000 00000000 0
0000104C 00000013 10000000 00000000 00000000 00000000 0 00000000 00000000 1
00001050 0000B283 10000000 00000000 00000000 00000000 0 00000000 00000000 1
00001054 0020B023 10000000 A1B2C3D4 00000000 00000000 0 00000000 00000000 1
00001058 0020A283 10000000 00000000 00000000 00000000 0 00000000 00000000 1
0000105C 00109283 10000000 00000000 00000000 00000000 0 00000000 00000000 1

/* sim/tb_check_tasks.svh */
`ifndef TB_CHECK_TASKS_SVH
`define TB_CHECK_TASKS_SVH

// failure counters summed up in the closing line
int mismatch_count = 0;
int other_count    = 0;
int timeout_count  = 0;

task automatic check_word(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                          input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
endtask

task automatic check_mask(input logic [`MASK_W-1:0] got, input logic [`MASK_W-1:0] exp,
                          input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

/* sim/rv32_stage_regs_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_pipe_defines.svh"

module rv32_stage_regs_tb
    import rv32_pipe_pkg::*;
;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 3;
    localparam int          TIMEOUT      = 20;
    localparam logic [15:0] LFSR_SEED    = 16'd25;
    localparam logic [31:0] IDLE_WORD    = 32'hDEAD_BEEF;

    logic               clk = 1'b0;
    logic               rst;
    logic               fetch_valid_i;
    logic [`XLEN-1:0]   instr_i;
    logic [`XLEN-1:0]   pc_i;
    logic [`XLEN-1:0]   rs1_data_i;
    logic [`XLEN-1:0]   rs2_data_i;
    logic [`XLEN-1:0]   mem_rdata_i;
    logic               mem_read_o;
    logic               mem_write_o;
    logic [`XLEN-1:0]   mem_addr_o;
    logic [`MASK_W-1:0] mem_be_o;
    logic [`XLEN-1:0]   mem_wdata_o;
    logic               wb_valid_o;
    logic               wb_trap_o;
    logic [`XLEN-1:0]   wb_pc_o;
    logic [`XLEN-1:0]   wb_data_o;

    // one entry per stimulus line
    logic [`XLEN-1:0]   st_pc[$];
    logic [`XLEN-1:0]   st_instr[$];
    logic [`XLEN-1:0]   st_rs1[$];
    logic [`XLEN-1:0]   st_rs2[$];
    logic [`XLEN-1:0]   st_rdata[$];
    logic [`XLEN-1:0]   st_addr[$];
    logic [`MASK_W-1:0] st_mask[$];
    logic [`XLEN-1:0]   st_wdata[$];
    logic [`XLEN-1:0]   st_wb[$];
    logic               st_trap[$];
    int                 cap_cyc[$];

    // items still expected at the memory port and at writeback
    int                 mem_q[$];
    int                 wb_q[$];

    int                 cyc = 0;
    logic [15:0]        lfsr_state;
    logic               op_pending = 1'b0;
    int                 op_idx = 0;

    `include "tb_check_tasks.svh"

    rv32_stage_regs rv32_stage_regs_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .mem_addr_o    (mem_addr_o),
        .mem_be_o      (mem_be_o),
        .mem_wdata_o   (mem_wdata_o),
        .wb_valid_o    (wb_valid_o),
        .wb_trap_o     (wb_trap_o),
        .wb_pc_o       (wb_pc_o),
        .wb_data_o     (wb_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // edge counter as the time base for latency checks
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // two bits per gap folded onto 0..2
    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        lfsr_state = lfsr_step(lfsr_state);
        bits[0]    = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        bits[1]    = lfsr_state[0];
        gap        = int'(bits) % 3;
    endtask

    function automatic logic expects_read(input int idx);
        return (st_instr[idx][6:0] == `OP_LOAD) && !st_trap[idx];
    endfunction

    function automatic logic expects_write(input int idx);
        return (st_instr[idx][6:0] == `OP_STORE) && !st_trap[idx];
    endfunction

    // same funct3 bits named as a load or a store
    function automatic string access_name(input int idx);
        mem_funct_u funct;
        string      name;
        funct = mem_funct_u'(st_instr[idx][14:12]);
        name  = "other";
        if (st_instr[idx][6:0] == `OP_LOAD) begin
            name = funct.load.name();
        end else if (st_instr[idx][6:0] == `OP_STORE) begin
            name = funct.store.name();
        end
        if (name == "") begin
            name = "bad funct3";
        end
        return name;
    endfunction

    task automatic load_stimulus();
        int                 fd;
        int                 n;
        string              line;
        logic [`XLEN-1:0]   v_pc, v_instr, v_rs1, v_rs2, v_rdata;
        logic [`XLEN-1:0]   v_addr, v_wdata, v_wb;
        logic [`MASK_W-1:0] v_mask;
        logic               v_trap;
        fd = $fopen("sim/rv32_stage_stim.txt", "r");
        if (fd == 0) begin
            other_count++;
            $display("cannot open the stimulus file sim/rv32_stage_stim.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v_pc, v_instr, v_rs1,
                            v_rs2, v_rdata, v_addr, v_mask, v_wdata, v_wb, v_trap);
                if (n == 10) begin
                    st_pc.push_back(v_pc);
                    st_instr.push_back(v_instr);
                    st_rs1.push_back(v_rs1);
                    st_rs2.push_back(v_rs2);
                    st_rdata.push_back(v_rdata);
                    st_addr.push_back(v_addr);
                    st_mask.push_back(v_mask);
                    st_wdata.push_back(v_wdata);
                    st_wb.push_back(v_wb);
                    st_trap.push_back(v_trap);
                    cap_cyc.push_back(0);
                end else if (n > 0) begin
                    other_count++;
                    $display("stimulus line has %0d fields instead of 10: %s", n, line);
                end
            end
        end
        $fclose(fd);
        if (st_pc.size() == 0) begin
            other_count++;
            $display("stimulus file holds no items");
        end
    endtask

    // operands belong to the item fetched one cycle earlier
    task automatic drive_operands();
        if (op_pending) begin
            rs1_data_i = st_rs1[op_idx];
            rs2_data_i = st_rs2[op_idx];
        end else begin
            rs1_data_i = IDLE_WORD;
            rs2_data_i = IDLE_WORD;
        end
        op_pending = 1'b0;
    endtask

    task automatic issue_item(input int idx);
        fetch_valid_i = 1'b1;
        instr_i       = st_instr[idx];
        pc_i          = st_pc[idx];
        cap_cyc[idx]  = cyc + 1;
        op_pending    = 1'b1;
        op_idx        = idx;
        wb_q.push_back(idx);
        if (expects_read(idx) || expects_write(idx)) begin
            mem_q.push_back(idx);
        end
    endtask

    // memory port monitor and read responder
    initial begin
        int    idx;
        string tag;
        mem_rdata_i = IDLE_WORD;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            mem_rdata_i = IDLE_WORD;
            if (!rst && (mem_read_o || mem_write_o)) begin
                if (mem_q.size() == 0) begin
                    other_count++;
                    $display("memory strobe at %0t ns with no access outstanding", $time);
                end else begin
                    idx = mem_q.pop_front();
                    tag = $sformatf("item %0d (%s)", idx, access_name(idx));
                    check_word(`XLEN'(cyc), `XLEN'(cap_cyc[idx] + 2), {tag, " strobe cycle"});
                    check_flag(mem_read_o, expects_read(idx), {tag, " mem_read_o"});
                    check_flag(mem_write_o, expects_write(idx), {tag, " mem_write_o"});
                    check_word(mem_addr_o, st_addr[idx], {tag, " mem_addr_o"});
                    check_mask(mem_be_o, st_mask[idx], {tag, " mem_be_o"});
                    if (mem_write_o) begin
                        check_word(mem_wdata_o, st_wdata[idx], {tag, " mem_wdata_o"});
                    end
                    if (mem_read_o) begin
                        mem_rdata_i = st_rdata[idx];
                    end
                end
            end
        end
    end

    // writeback scoreboard
    initial begin
        int    idx;
        string tag;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (!rst && wb_valid_o) begin
                if (wb_q.size() == 0) begin
                    other_count++;
                    $display("writeback at %0t ns with no item outstanding", $time);
                end else begin
                    idx = wb_q.pop_front();
                    tag = $sformatf("item %0d (%s)", idx, access_name(idx));
                    check_word(`XLEN'(cyc), `XLEN'(cap_cyc[idx] + 3), {tag, " wb cycle"});
                    check_word(wb_pc_o, st_pc[idx], {tag, " wb_pc_o"});
                    check_word(wb_data_o, st_wb[idx], {tag, " wb_data_o"});
                    check_flag(wb_trap_o, st_trap[idx], {tag, " wb_trap_o"});
                end
            end
        end
    end

    initial begin
        int idx;
        int gap;
        int stall;
        int pending;
        rst           = 1'b1;
        fetch_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rs1_data_i    = IDLE_WORD;
        rs2_data_i    = IDLE_WORD;
        lfsr_state    = LFSR_SEED;
        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // quiet outputs before the first issue
        repeat (4) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_flag(mem_read_o, 1'b0, "idle mem_read_o");
            check_flag(mem_write_o, 1'b0, "idle mem_write_o");
            check_flag(wb_valid_o, 1'b0, "idle wb_valid_o");
        end

        for (idx = 0; idx < st_pc.size(); idx++) begin
            draw_gap(gap);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                #DRIVE_DLY;
                drive_operands();
                fetch_valid_i = 1'b0;
            end
            @(posedge clk);
            #DRIVE_DLY;
            drive_operands();
            issue_item(idx);
        end
        @(posedge clk);
        #DRIVE_DLY;
        drive_operands();
        fetch_valid_i = 1'b0;

        // the drain timeout restarts on every writeback
        stall = 0;
        while (wb_q.size() != 0 && stall < TIMEOUT) begin
            pending = wb_q.size();
            @(negedge clk);
            if (wb_q.size() < pending) begin
                stall = 0;
            end else begin
                stall++;
            end
        end
        if (wb_q.size() != 0) begin
            timeout_count++;
            $display("timeout: %0d items did not reach writeback within %0d cycles",
                     wb_q.size(), TIMEOUT);
        end
        if (mem_q.size() != 0) begin
            other_count++;
            $display("%0d expected memory strobes never appeared", mem_q.size());
        end

        // stray strobes after the last item
        repeat (4) @(posedge clk);
        #DRIVE_DLY;

        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatch_count, other_count, timeout_count);
        if (mismatch_count == 0 && other_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : rv32_stage_regs_tb

`default_nettype wire

/* verilog/rv32_stage_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_pipe_defines.svh"

module rv32_stage_regs
    import rv32_pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid_i,
    input  logic [`XLEN-1:0]   instr_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  logic [`XLEN-1:0]   rs1_data_i,
    input  logic [`XLEN-1:0]   rs2_data_i,
    input  logic [`XLEN-1:0]   mem_rdata_i,
    output logic               mem_read_o,
    output logic               mem_write_o,
    output logic [`XLEN-1:0]   mem_addr_o,
    output logic [`MASK_W-1:0] mem_be_o,
    output logic [`XLEN-1:0]   mem_wdata_o,
    output logic               wb_valid_o,
    output logic               wb_trap_o,
    output logic [`XLEN-1:0]   wb_pc_o,
    output logic [`XLEN-1:0]   wb_data_o
);

    // fetch/decode to decode/execute
    logic             fd_valid;
    logic             fd_is_load;
    logic             fd_is_store;
    logic             fd_illegal;
    mem_funct_u       fd_funct;
    logic [`XLEN-1:0] fd_imm;
    logic [`XLEN-1:0] fd_pc;

    // decode/execute to execute/memory
    logic             de_valid;
    logic             de_is_load;
    logic             de_is_store;
    logic             de_illegal;
    mem_funct_u       de_funct;
    logic [`XLEN-1:0] de_imm;
    logic [`XLEN-1:0] de_pc;
    logic [`XLEN-1:0] de_rs1;
    logic [`XLEN-1:0] de_rs2;

    // execute/memory to writeback
    logic             em_valid;
    mem_funct_u       em_funct;
    logic             em_is_load;
    logic             em_trap;
    logic [1:0]       em_offset;
    logic [`XLEN-1:0] em_pc;

    fet_dec_stage fet_dec_stage_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .fd_valid_o    (fd_valid),
        .is_load_o     (fd_is_load),
        .is_store_o    (fd_is_store),
        .funct_o       (fd_funct),
        .imm_o         (fd_imm),
        .pc_o          (fd_pc),
        .illegal_o     (fd_illegal)
    );

    dec_exe_reg dec_exe_reg_i (
        .clk        (clk),
        .rst        (rst),
        .fd_valid_i (fd_valid),
        .is_load_i  (fd_is_load),
        .is_store_i (fd_is_store),
        .illegal_i  (fd_illegal),
        .funct_i    (fd_funct),
        .imm_i      (fd_imm),
        .pc_i       (fd_pc),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .de_valid_o (de_valid),
        .is_load_o  (de_is_load),
        .is_store_o (de_is_store),
        .illegal_o  (de_illegal),
        .funct_o    (de_funct),
        .imm_o      (de_imm),
        .pc_o       (de_pc),
        .rs1_o      (de_rs1),
        .rs2_o      (de_rs2)
    );

    exe_mem_reg exe_mem_reg_i (
        .clk           (clk),
        .rst           (rst),
        .de_valid_i    (de_valid),
        .de_is_load_i  (de_is_load),
        .de_is_store_i (de_is_store),
        .de_illegal_i  (de_illegal),
        .de_funct_i    (de_funct),
        .de_imm_i      (de_imm),
        .de_pc_i       (de_pc),
        .de_rs1_i      (de_rs1),
        .de_rs2_i      (de_rs2),
        .em_valid_o    (em_valid),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_be_o      (mem_be_o),
        .em_funct_o    (em_funct),
        .em_is_load_o  (em_is_load),
        .em_trap_o     (em_trap),
        .em_offset_o   (em_offset),
        .em_pc_o       (em_pc)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk          (clk),
        .rst          (rst),
        .em_valid_i   (em_valid),
        .em_is_load_i (em_is_load),
        .em_trap_i    (em_trap),
        .em_funct_i   (em_funct),
        .em_offset_i  (em_offset),
        .em_pc_i      (em_pc),
        .mem_rdata_i  (mem_rdata_i),
        .wb_valid_o   (wb_valid_o),
        .wb_trap_o    (wb_trap_o),
        .wb_pc_o      (wb_pc_o),
        .wb_data_o    (wb_data_o)
    );

endmodule : rv32_stage_regs

`default_nettype wire

/* verilog/mem_wb_reg.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_pipe_defines.svh"

module mem_wb_reg
    import rv32_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             em_valid_i,
    input  logic             em_is_load_i,
    input  logic             em_trap_i,
    input  mem_funct_u       em_funct_i,
    input  logic [1:0]       em_offset_i,
    input  logic [`XLEN-1:0] em_pc_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    output logic             wb_valid_o,
    output logic             wb_trap_o,
    output logic [`XLEN-1:0] wb_pc_o,
    output logic [`XLEN-1:0] wb_data_o
);

    logic [`XLEN-1:0] shifted;
    logic [`XLEN-1:0] load_data;

    // addressed byte or half lands in the low lanes
    assign shifted = mem_rdata_i >> {em_offset_i, 3'b000};

    always_comb begin
        load_data = '0;
        // stores and traps write back zero
        if (em_is_load_i && !em_trap_i) begin
            case (em_funct_i.load)
                lb:      load_data = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
                lh:      load_data = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
                lw:      load_data = shifted;
                lbu:     load_data = {{(`XLEN-8){1'b0}}, shifted[7:0]};
                lhu:     load_data = {{(`XLEN-16){1'b0}}, shifted[15:0]};
                default: load_data = '0;
            endcase
        end
    end

    // read word is sampled on the edge that ends the memory cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_trap_o  <= 1'b0;
            wb_pc_o    <= `RESET_PC;
            wb_data_o  <= '0;
        end else begin
            wb_valid_o <= em_valid_i;
            wb_trap_o  <= em_valid_i && em_trap_i;
            if (em_valid_i) begin
                wb_pc_o   <= em_pc_i;
                wb_data_o <= load_data;
            end
        end
    end

endmodule : mem_wb_reg

`default_nettype wire

/* verilog/exe_mem_reg.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_pipe_defines.svh"

module exe_mem_reg
    import rv32_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              de_valid_i,
    input  logic              de_is_load_i,
    input  logic              de_is_store_i,
    input  logic              de_illegal_i,
    input  mem_funct_u        de_funct_i,
    input  logic [`XLEN-1:0]  de_imm_i,
    input  logic [`XLEN-1:0]  de_pc_i,
    input  logic [`XLEN-1:0]  de_rs1_i,
    input  logic [`XLEN-1:0]  de_rs2_i,
    output logic              em_valid_o,
    output logic              mem_read_o,
    output logic              mem_write_o,
    output logic [`XLEN-1:0]  mem_addr_o,
    output logic [`XLEN-1:0]  mem_wdata_o,
    output logic [`MASK_W-1:0] mem_be_o,
    output mem_funct_u        em_funct_o,
    output logic              em_is_load_o,
    output logic              em_trap_o,
    output logic [1:0]        em_offset_o,
    output logic [`XLEN-1:0]  em_pc_o
);

    logic [`XLEN-1:0]  eff_addr;
    logic [1:0]        offset;
    logic              acc_word;
    logic              acc_half;
    logic              misaligned;
    logic              trap;
    logic [`MASK_W-1:0] base_mask;
    logic [`MASK_W-1:0] lane_mask;
    logic [`XLEN-1:0]  lane_data;

    assign eff_addr = de_rs1_i + de_imm_i;
    assign offset   = eff_addr[1:0];

    // anything not word or half is a byte access
    always_comb begin
        acc_word = 1'b0;
        acc_half = 1'b0;
        if (de_is_load_i) begin
            acc_word = (de_funct_i.load == lw);
            acc_half = (de_funct_i.load == lh) || (de_funct_i.load == lhu);
        end else begin
            acc_word = (de_funct_i.store == sw);
            acc_half = (de_funct_i.store == sh);
        end
    end

    assign misaligned = (acc_word && (offset != 2'b00)) || (acc_half && offset[0]);
    assign trap       = de_illegal_i || misaligned;

    assign base_mask = acc_word ? {`MASK_W{1'b1}} :
                       acc_half ? `MASK_W'(2'b11) : `MASK_W'(1'b1);
    assign lane_mask = trap ? '0 : (base_mask << offset);

    // store data moves up into its byte lanes
    assign lane_data = de_rs2_i << {offset, 3'b000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            em_valid_o   <= 1'b0;
            mem_read_o   <= 1'b0;
            mem_write_o  <= 1'b0;
            mem_be_o     <= '0;
            em_trap_o    <= 1'b0;
            mem_addr_o   <= '0;
            mem_wdata_o  <= '0;
            em_funct_o   <= '0;
            em_is_load_o <= 1'b0;
            em_offset_o  <= 2'b00;
            em_pc_o      <= `RESET_PC;
        end else begin
            em_valid_o  <= de_valid_i;
            mem_read_o  <= de_valid_i && de_is_load_i && !trap;
            mem_write_o <= de_valid_i && de_is_store_i && !trap;
            mem_be_o    <= de_valid_i ? lane_mask : '0;
            em_trap_o   <= de_valid_i && trap;
            if (de_valid_i) begin
                mem_addr_o   <= {eff_addr[`XLEN-1:2], 2'b00};
                mem_wdata_o  <= de_is_store_i ? lane_data : '0;
                em_funct_o   <= de_funct_i;
                em_is_load_o <= de_is_load_i;
                em_offset_o  <= offset;
                em_pc_o      <= de_pc_i;
            end
        end
    end

endmodule : exe_mem_reg

`default_nettype wire

/* verilog/dec_exe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_pipe_defines.svh"

module dec_exe_reg
    import rv32_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             fd_valid_i,
    input  logic             is_load_i,
    input  logic             is_store_i,
    input  logic             illegal_i,
    input  mem_funct_u       funct_i,
    input  logic [`XLEN-1:0] imm_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output logic             de_valid_o,
    output logic             is_load_o,
    output logic             is_store_o,
    output logic             illegal_o,
    output mem_funct_u       funct_o,
    output logic [`XLEN-1:0] imm_o,
    output logic [`XLEN-1:0] pc_o,
    output logic [`XLEN-1:0] rs1_o,
    output logic [`XLEN-1:0] rs2_o
);

    // operands arrive in the decode cycle, so they pair with the decoded fields here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_valid_o <= 1'b0;
            is_load_o  <= 1'b0;
            is_store_o <= 1'b0;
            illegal_o  <= 1'b0;
            funct_o    <= '0;
            imm_o      <= '0;
            pc_o       <= `RESET_PC;
            rs1_o      <= '0;
            rs2_o      <= '0;
        end else begin
            de_valid_o <= fd_valid_i;
            // payload holds through bubbles
            if (fd_valid_i) begin
                is_load_o  <= is_load_i;
                is_store_o <= is_store_i;
                illegal_o  <= illegal_i;
                funct_o    <= funct_i;
                imm_o      <= imm_i;
                pc_o       <= pc_i;
                rs1_o      <= rs1_data_i;
                rs2_o      <= rs2_data_i;
            end
        end
    end

endmodule : dec_exe_reg

`default_nettype wire

/* verilog/fet_dec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv32_pipe_defines.svh"

module fet_dec_stage
    import rv32_pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_valid_i,
    input  logic [`XLEN-1:0] instr_i,
    input  logic [`XLEN-1:0] pc_i,
    output logic             fd_valid_o,
    output logic             is_load_o,
    output logic             is_store_o,
    output mem_funct_u       funct_o,
    output logic [`XLEN-1:0] imm_o,
    output logic [`XLEN-1:0] pc_o,
    output logic             illegal_o
);

    logic             valid_q;
    logic [`XLEN-1:0] instr_q;
    logic [`XLEN-1:0] pc_q;
    logic [6:0]       opcode;
    logic             funct_ok;

    // a missing strobe leaves a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            instr_q <= '0;
            pc_q    <= `RESET_PC;
        end else begin
            valid_q <= fetch_valid_i;
            instr_q <= instr_i;
            pc_q    <= pc_i;
        end
    end

    assign opcode     = instr_q[6:0];
    assign is_load_o  = (opcode == `OP_LOAD);
    assign is_store_o = (opcode == `OP_STORE);
    assign funct_o    = mem_funct_u'(instr_q[14:12]);

    // loads and stores read the same funct3 bits
    always_comb begin
        funct_ok = 1'b0;
        if (is_load_o) begin
            case (funct_o.load)
                lb, lh, lw, lbu, lhu: funct_ok = 1'b1;
                default:              funct_ok = 1'b0;
            endcase
        end else if (is_store_o) begin
            case (funct_o.store)
                sb, sh, sw: funct_ok = 1'b1;
                default:    funct_ok = 1'b0;
            endcase
        end
    end

    // unknown opcodes never set funct_ok
    assign illegal_o = ~funct_ok;

    // s-type offset is split around the rd field
    always_comb begin
        if (is_store_o) begin
            imm_o = {{(`XLEN-12){instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
        end else begin
            imm_o = {{(`XLEN-12){instr_q[31]}}, instr_q[31:20]};
        end
    end

    assign fd_valid_o = valid_q;
    assign pc_o       = pc_q;

endmodule : fet_dec_stage

`default_nettype wire

/* verilog/rv32_pipe_pkg.sv */
`default_nettype none

package rv32_pipe_pkg;

    // funct3 encodings of the rv32i loads
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // funct3 encodings of the rv32i stores
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // one funct3 field read as a load or as a store by opcode
    typedef union packed {
        load_funct3_e  load;
        store_funct3_e store;
    } mem_funct_u;

endpackage : rv32_pipe_pkg

`default_nettype wire

/* verilog/rv32_pipe_defines.svh */
`ifndef RV32_PIPE_DEFINES_SVH
`define RV32_PIPE_DEFINES_SVH

// data and address width
`define XLEN 32

// one enable bit per byte lane
`define MASK_W 4

// value that every pc register takes on reset
`define RESET_PC 32'h4000_0000

// major opcodes in bits [6:0] of the instruction
`define OP_LOAD  7'b000_0011
`define OP_STORE 7'b010_0011

`endif
